// File: files.f
verilog/stm_drive_pkg.sv
verilog/stm_bus_pkg.sv
verilog/stm_host_decode.sv
verilog/stm_gain_ram.sv
verilog/stm_gain_operator.sv
verilog/stm_drive_limiter.sv
verilog/stm_top.sv
verification/stm_checker.sv
verification/stm_asserts.sv
verification/stm_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module stm_tb -Mdir obj_dir -f files.f \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vstm_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test OK" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: verification/stm_asserts.sv
// ------------------------------------------------------------
// Assertions on the Wishbone handshake and the operator FSM
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_asserts #(
    parameter int ROW_BITS   = 2,
    parameter bit BUS_CHECKS = 1'b1                     // Handshake side, else operator side
) (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              cyc,
    input  wire                              stb,
    input  wire                              ack,
    input  wire                              start,
    input  wire                              done,
    input  wire stm_drive_pkg::gain_state_t  state
);

    localparam int DONE_LAT = 3 + 2 ** ROW_BITS;        // Waits, rows, buffer

    int fail_count;

    initial begin
        fail_count = 0;
    end

    generate
        if (BUS_CHECKS) begin : g_bus
            // ------------------------------------------------------------
            // Bus handshake
            // ------------------------------------------------------------
            ack_single: assert property (@(posedge CLK) disable iff (RST) ack |=> !ack)
                else begin
                    $error("ack held high for two cycles");
                    fail_count++;
                end

            ack_request: assert property (@(posedge CLK) disable iff (RST)
                ack |-> $past(cyc && stb && !ack))
                else begin
                    $error("ack without a preceding cyc and stb");
                    fail_count++;
                end
        end else begin : g_operator
            // ------------------------------------------------------------
            // Operator
            // ------------------------------------------------------------
            done_latency: assert property (@(posedge CLK) disable iff (RST)
                done == $past(start && state == stm_drive_pkg::ST_IDLE, DONE_LAT))
                else begin
                    $error("done not exactly %0d cycles after start", DONE_LAT);
                    fail_count++;
                end

            idle_hold: assert property (@(posedge CLK) disable iff (RST)
                (state == stm_drive_pkg::ST_IDLE && !start) |=> state == stm_drive_pkg::ST_IDLE)
                else begin
                    $error("operator left idle without start");
                    fail_count++;
                end
        end
    endgenerate

endmodule

bind stm_host_decode stm_asserts #(.ROW_BITS(ROW_BITS), .BUS_CHECKS(1'b1)) u_bus_asserts (
    .CLK   (CLK),
    .RST   (RST),
    .cyc   (wb_req.cyc),
    .stb   (wb_req.stb),
    .ack   (ack),
    .start (1'b0),
    .done  (1'b0),
    .state (stm_drive_pkg::ST_IDLE)
);

bind stm_gain_operator stm_asserts #(.ROW_BITS(ROW_BITS), .BUS_CHECKS(1'b0)) u_op_asserts (
    .CLK   (CLK),
    .RST   (RST),
    .cyc   (1'b0),
    .stb   (1'b0),
    .ack   (1'b0),
    .start (start),
    .done  (done),
    .state (state)
);

`default_nettype wire

// File: verification/stm_checker.sv
// ------------------------------------------------------------
// Result checker: compares DRIVE on each UPDATE and register
// reads with expected values, keeps per-test counts
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_checker #(
    parameter int DEPTH = 10
) (
    input  wire                                         CLK,
    input  wire                                         RST,
    input  wire stm_drive_pkg::chan_drive_t [DEPTH-1:0] drive,
    input  wire                                         update,
    input  wire stm_bus_pkg::wb_rsp_t                   wb_rsp,
    input  wire stm_drive_pkg::chan_drive_t [DEPTH-1:0] exp_drive,
    input  wire                                         rd_check,
    input  wire [31:0]                                  rd_expect,
    input  wire                                         quiet,     // No UPDATE allowed
    input  wire                                         test_end,
    input  wire [31:0]                                  test_id,
    output int                                          errors,
    output int                                          checks,
    output int                                          updates
);

    int chk_base;
    int err_base;

    function automatic string test_name(input int id);
        case (id)
            1:       return "register read-back";
            2:       return "normal format load";
            3:       return "legacy format";
            4:       return "limiter";
            5:       return "unchanged index";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare_drive();
        for (int ch = 0; ch < DEPTH; ch++) begin
            checks++;
            if (drive[ch] !== exp_drive[ch]) begin
                errors++;
                $display("Error at %0d ns: channel %0d phase %0d duty %0d, expected phase %0d duty %0d",
                         $time, ch, drive[ch].phase, drive[ch].duty,
                         exp_drive[ch].phase, exp_drive[ch].duty);
            end
        end
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        updates  = 0;
        chk_base = 0;
        err_base = 0;
    end

    // Outputs sampled before the edge updates them
    always @(posedge CLK) begin
        if (!RST) begin
            if (update) begin
                updates++;
            end
            if (update && quiet) begin
                errors++;
                $display("UPDATE pulsed at %0d ns after the index was rewritten unchanged", $time);
            end
            if (update || quiet) begin
                compare_drive();                        // Held values too
            end
            if (rd_check && wb_rsp.ack) begin
                checks++;
                if (wb_rsp.dat !== rd_expect) begin
                    errors++;
                    $display("Error at %0d ns: register read returned 0x%08h, expected 0x%08h",
                             $time, wb_rsp.dat, rd_expect);
                end
            end
            if (test_end) begin
                $display("Test %0d %s: %0d checks, %0d errors", test_id,
                         test_name(int'(test_id)), checks - chk_base, errors - err_base);
                chk_base = checks;
                err_base = errors;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/stm_tb.sv
// ------------------------------------------------------------
// Testbench for the gain sequence top: host bus stimulus,
// frame loads and the expected drive model
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_tb;

    localparam int DEPTH      = 10;
    localparam int FRAME_BITS = 3;
    localparam int ROW_BITS   = 2;
    localparam int FRAMES     = 2 ** FRAME_BITS;
    localparam int WORDS      = 4 * 2 ** ROW_BITS;      // Memory words per frame
    localparam int TIMEOUT    = 200;                    // Cycles

    typedef stm_drive_pkg::chan_drive_t [DEPTH-1:0] frame_drive_t;

    logic                              CLK;
    logic                              RST;
    stm_bus_pkg::wb_req_t              wb_req;
    stm_bus_pkg::wb_rsp_t              wb_rsp;
    frame_drive_t                      DRIVE;
    logic                              UPDATE;

    frame_drive_t                      exp_drive;
    logic                              rd_check;
    logic [31:0]                       rd_expect;
    logic                              quiet;
    logic                              test_end;
    logic [31:0]                       test_id;
    int                                errors;
    int                                checks;
    int                                updates;

    logic [31:0]                       host_mem [FRAMES*WORDS];    // Copy of gain memory
    logic [stm_drive_pkg::DRIVE_W-1:0] cur_cycle;
    logic                              cur_legacy;
    int                                index_changes;

    stm_top #(
        .DEPTH      (DEPTH),
        .FRAME_BITS (FRAME_BITS),
        .ROW_BITS   (ROW_BITS)
    ) u_stm_top (
        .CLK    (CLK),
        .RST    (RST),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .DRIVE  (DRIVE),
        .UPDATE (UPDATE)
    );

    stm_checker #(
        .DEPTH (DEPTH)
    ) u_checker (
        .CLK       (CLK),
        .RST       (RST),
        .drive     (DRIVE),
        .update    (UPDATE),
        .wb_rsp    (wb_rsp),
        .exp_drive (exp_drive),
        .rd_check  (rd_check),
        .rd_expect (rd_expect),
        .quiet     (quiet),
        .test_end  (test_end),
        .test_id   (test_id),
        .errors    (errors),
        .checks    (checks),
        .updates   (updates)
    );

    always #10 CLK = ~CLK;

    // Unpack then limit, per channel of one frame
    function automatic frame_drive_t expected_drive(
        input int                                frame,
        input logic                              legacy,
        input logic [stm_drive_pkg::DRIVE_W-1:0] cyc_len
    );
        frame_drive_t exp;
        logic [31:0]  word;
        int           phase;
        int           duty;
        for (int ch = 0; ch < DEPTH; ch++) begin
            word = host_mem[frame * WORDS + ch];
            if (legacy) begin
                phase = int'(word[7:0]) * 32;
                duty  = int'(word[23:16]) * 8 + 8;
            end else begin
                phase = int'(word[15:0]) % 8192;
                duty  = int'(word[31:16]) % 8192;
            end
            if (duty > int'(cyc_len) / 2) duty = int'(cyc_len) / 2;
            if (phase >= int'(cyc_len)) phase = phase - int'(cyc_len);
            exp[ch].phase = 13'(phase);
            exp[ch].duty  = 13'(duty);
        end
        return exp;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic bus_access(
        input  logic        we,
        input  logic [7:0]  adr,
        input  logic [31:0] dat,
        output logic [31:0] rdat
    );
        int wait_cnt;
        @(negedge CLK);
        wb_req   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        wait_cnt = 0;
        do begin
            @(negedge CLK);
            wait_cnt++;
        end while (!wb_rsp.ack && wait_cnt < TIMEOUT);
        if (!wb_rsp.ack) begin
            abort_run($sformatf("Bus access to address 0x%02h was never acknowledged", adr));
        end else begin
            rdat       = wb_rsp.dat;
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
        end
    endtask

    task automatic write_word(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused_rdat;
        bus_access(1'b1, adr, dat, unused_rdat);
    endtask

    task automatic write_mem(input int addr, input logic [31:0] dat);
        write_word(8'(addr), dat);
        host_mem[addr] = dat;
    endtask

    task automatic set_mode(input logic legacy);
        write_word(stm_bus_pkg::REG_MODE, {31'd0, legacy});
        cur_legacy = legacy;
    endtask

    task automatic set_cycle(input logic [stm_drive_pkg::DRIVE_W-1:0] value);
        write_word(stm_bus_pkg::REG_CYCLE, 32'(value));
        cur_cycle = value;
    endtask

    task automatic check_read(input logic [7:0] adr, input logic [31:0] value);
        logic [31:0] rdat;
        @(negedge CLK);
        rd_expect = value;
        rd_check  = 1'b1;
        bus_access(1'b0, adr, 32'd0, rdat);
        @(negedge CLK);
        rd_check = 1'b0;
    endtask

    // Frame must differ from the current index
    task automatic select_frame(input int frame);
        int seen;
        int wait_cnt;
        seen      = updates;
        exp_drive = expected_drive(frame, cur_legacy, cur_cycle);
        write_word(stm_bus_pkg::REG_INDEX, 32'(frame));
        index_changes++;
        wait_cnt = 0;
        while (updates == seen && wait_cnt < TIMEOUT) begin
            @(negedge CLK);
            wait_cnt++;
        end
        if (updates == seen) begin
            abort_run($sformatf("No UPDATE after selecting frame %0d", frame));
        end
    endtask

    task automatic end_test(input int id);
        @(negedge CLK);
        test_id  = 32'(id);
        test_end = 1'b1;
        @(negedge CLK);
        test_end = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        logic [15:0]                       phase_f;
        logic [15:0]                       duty_f;
        logic [stm_drive_pkg::DRIVE_W-1:0] lim;
        int                                assert_fails;
        CLK           = 1'b0;
        RST           = 1'b1;
        wb_req        = '0;
        exp_drive     = '0;
        rd_check      = 1'b0;
        rd_expect     = 32'd0;
        quiet         = 1'b0;
        test_end      = 1'b0;
        test_id       = 32'd0;
        cur_cycle     = '0;
        cur_legacy    = 1'b0;
        index_changes = 0;
        void'($urandom(32'h9c52ae45));
        repeat (16) @(negedge CLK);
        RST = 1'b0;

        check_read(stm_bus_pkg::REG_UPDATES, 32'd0);
        set_mode(1'b1);
        check_read(stm_bus_pkg::REG_MODE, 32'd1);
        set_mode(1'b0);
        check_read(stm_bus_pkg::REG_MODE, 32'd0);
        set_cycle(13'd8191);
        check_read(stm_bus_pkg::REG_CYCLE, 32'd8191);
        for (int w = 0; w < WORDS; w++) write_mem(5 * WORDS + w, $urandom() & 32'hEFFF_EFFF);
        select_frame(5);
        check_read(stm_bus_pkg::REG_INDEX, 32'd5);
        end_test(1);

        // Bit 12 clear keeps duty under half the cycle
        for (int f = 0; f < FRAMES; f++) begin
            for (int w = 0; w < WORDS; w++) write_mem(f * WORDS + w, $urandom() & 32'hEFFF_EFFF);
        end
        for (int f = 1; f <= FRAMES; f++) select_frame((5 + f) % FRAMES);
        end_test(2);

        set_mode(1'b1);
        for (int w = 0; w < WORDS; w++) write_mem(2 * WORDS + w, $urandom());
        for (int w = 0; w < WORDS; w++) write_mem(6 * WORDS + w, $urandom());
        select_frame(2);
        select_frame(6);
        end_test(3);

        set_mode(1'b0);
        for (int k = 0; k < 2; k++) begin
            lim = 13'(600 + k);                         // Even and odd cycle
            set_cycle(lim);
            for (int w = 0; w < WORDS; w++) begin
                phase_f = 16'(int'(lim) - 4 + int'($urandom() % 9) + (w % 2) * int'(lim) / 2);
                duty_f  = 16'(int'(lim) / 2 - 3 + int'($urandom() % 7));
                write_mem((3 + k) * WORDS + w, {duty_f, phase_f});
            end
            select_frame(3 + k);
        end
        end_test(4);

        select_frame(1);
        quiet = 1'b1;
        write_word(stm_bus_pkg::REG_INDEX, 32'd1);
        repeat (20) @(negedge CLK);                     // Longer than a full frame load
        quiet = 1'b0;
        check_read(stm_bus_pkg::REG_UPDATES, 32'(index_changes));
        end_test(5);

        @(negedge CLK);
        assert_fails = u_stm_top.u_decode.u_bus_asserts.fail_count
                     + u_stm_top.u_operator.u_op_asserts.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 assert_fails);
        if (errors == 0 && assert_fails == 0 && checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/stm_bus_pkg.sv
// ------------------------------------------------------------
// Host bus definitions: Wishbone request and response,
// host register map
// ------------------------------------------------------------
`default_nettype none

package stm_bus_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;       // Word address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Word addresses below 0x80 select the gain memory
    typedef enum logic [7:0] {
        REG_INDEX   = 8'h80,
        REG_MODE    = 8'h81,
        REG_CYCLE   = 8'h82,
        REG_UPDATES = 8'h83
    } host_reg_t;

endpackage

`default_nettype wire

// File: verilog/stm_drive_limiter.sv
// ------------------------------------------------------------
// Drive limiter: clamps duty to half the cycle, wraps phase
// once against the cycle and registers the drive words
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_drive_limiter #(
    parameter int DEPTH = 10
) (
    input  wire                                      CLK,
    input  wire                                      RST,
    input  wire stm_drive_pkg::chan_drive_t [DEPTH-1:0] drive_buf,
    input  wire                                      done,
    input  wire [stm_drive_pkg::DRIVE_W-1:0]         cycle,
    output stm_drive_pkg::chan_drive_t [DEPTH-1:0]   drive,
    output logic                                     update
);

    logic [stm_drive_pkg::DRIVE_W-1:0] half;

    assign half = cycle >> 1;                           // Rounded down

    always_ff @(posedge CLK) begin
        if (RST) begin
            drive  <= '0;
            update <= 1'b0;
        end else begin
            update <= done;
            if (done) begin
                for (int i = 0; i < DEPTH; i++) begin
                    drive[i].duty <= (drive_buf[i].duty > half) ? half
                                                                : drive_buf[i].duty;
                    // Single wrap only
                    drive[i].phase <= (drive_buf[i].phase >= cycle)
                                      ? drive_buf[i].phase - cycle
                                      : drive_buf[i].phase;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/stm_drive_pkg.sv
// ------------------------------------------------------------
// Drive definitions: value width, gain row layout, unpack
// format and operator FSM states
// ------------------------------------------------------------
`default_nettype none

package stm_drive_pkg;

    localparam int DRIVE_W    = 13;     // Fixed by the 16-bit field layout
    localparam int CH_PER_ROW = 4;

    // One channel slot of a memory row, phase in the low half
    typedef struct packed {
        logic [15:0] duty;
        logic [15:0] phase;
    } gain_slot_t;

    typedef gain_slot_t [CH_PER_ROW-1:0] gain_row_t;   // Slot 0 in low bits

    typedef struct packed {
        logic [DRIVE_W-1:0] duty;
        logic [DRIVE_W-1:0] phase;
    } chan_drive_t;

    typedef enum logic {
        FMT_NORMAL,
        FMT_LEGACY
    } gain_fmt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT0,
        ST_WAIT1,
        ST_SET,
        ST_BUF
    } gain_state_t;

endpackage

`default_nettype wire

// File: verilog/stm_gain_operator.sv
// ------------------------------------------------------------
// Gain operator: fetches a frame on index change, unpacks
// rows into a shadow buffer and double-buffers the result
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_gain_operator #(
    parameter int DEPTH      = 10,
    parameter int FRAME_BITS = 3,
    parameter int ROW_BITS   = 2
) (
    input  wire                                      CLK,
    input  wire                                      RST,
    input  wire [FRAME_BITS-1:0]                     frame_index,
    input  wire stm_drive_pkg::gain_fmt_t            fmt,
    output logic [FRAME_BITS+ROW_BITS-1:0]           rd_row,
    input  wire stm_drive_pkg::gain_row_t            rdata,
    output stm_drive_pkg::chan_drive_t [DEPTH-1:0]   drive_buf,
    output logic                                     done
);

    stm_drive_pkg::gain_state_t                state;
    stm_drive_pkg::chan_drive_t [DEPTH-1:0]    shadow;
    stm_drive_pkg::chan_drive_t [DEPTH-1:0]    shadow_next;

    logic [FRAME_BITS-1:0] idx_old;
    logic                  start;
    logic [FRAME_BITS-1:0] frame_q;
    logic [ROW_BITS-1:0]   rd_off;
    logic [ROW_BITS-1:0]   set_cnt;                     // Row now on rdata
    logic                  last_row;

    function automatic stm_drive_pkg::chan_drive_t unpack_slot(
        input stm_drive_pkg::gain_slot_t slot,
        input stm_drive_pkg::gain_fmt_t  f
    );
        stm_drive_pkg::chan_drive_t d;
        if (f == stm_drive_pkg::FMT_LEGACY) begin
            d.phase = {slot.phase[7:0], 5'd0};
            d.duty  = {2'b00, slot.duty[7:0], 3'd0} + 13'd8;
        end else begin
            d.phase = slot.phase[stm_drive_pkg::DRIVE_W-1:0];
            d.duty  = slot.duty[stm_drive_pkg::DRIVE_W-1:0];
        end
        return d;
    endfunction

    assign rd_row   = {frame_q, rd_off};
    assign last_row = (state == stm_drive_pkg::ST_SET) && (set_cnt == '1);

    // Current row merged into the shadow, slots past DEPTH dropped
    always_comb begin
        int ch;
        shadow_next = shadow;
        for (int k = 0; k < stm_drive_pkg::CH_PER_ROW; k++) begin
            ch = int'(set_cnt) * stm_drive_pkg::CH_PER_ROW + k;
            if (ch < DEPTH) begin
                shadow_next[ch] = unpack_slot(rdata[k], fmt);
            end
        end
    end

    // ------------------------------------------------------------
    // Fetch FSM
    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RST) begin
            idx_old <= '0;
            start   <= 1'b0;
            state   <= stm_drive_pkg::ST_IDLE;
            frame_q <= '0;
            rd_off  <= '0;
            set_cnt <= '0;
            done    <= 1'b0;
        end else begin
            idx_old <= frame_index;
            start   <= (frame_index != idx_old);
            done    <= last_row;                        // High during ST_BUF
            case (state)
                stm_drive_pkg::ST_IDLE: begin
                    if (start) begin
                        frame_q <= frame_index;
                        rd_off  <= '0;
                        state   <= stm_drive_pkg::ST_WAIT0;
                    end
                end
                stm_drive_pkg::ST_WAIT0: begin
                    rd_off <= rd_off + 1'b1;
                    state  <= stm_drive_pkg::ST_WAIT1;
                end
                stm_drive_pkg::ST_WAIT1: begin
                    rd_off  <= rd_off + 1'b1;
                    set_cnt <= '0;
                    state   <= stm_drive_pkg::ST_SET;   // Row 0 arrives next
                end
                stm_drive_pkg::ST_SET: begin
                    rd_off  <= rd_off + 1'b1;
                    set_cnt <= set_cnt + 1'b1;
                    if (last_row) begin
                        state <= stm_drive_pkg::ST_BUF;
                    end
                end
                default: state <= stm_drive_pkg::ST_IDLE;
            endcase
        end
    end

    // Shadow fill; the full frame moves to drive_buf as ST_BUF opens
    always_ff @(posedge CLK) begin
        if (state == stm_drive_pkg::ST_SET) begin
            shadow <= shadow_next;
        end
        if (last_row) begin
            drive_buf <= shadow_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/stm_gain_ram.sv
// ------------------------------------------------------------
// Gain memory: 32-bit slot writes, 128-bit row reads with
// two registered read stages
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_gain_ram #(
    parameter int FRAME_BITS = 3,
    parameter int ROW_BITS   = 2
) (
    input  wire                              CLK,
    input  wire                              we,
    input  wire [FRAME_BITS+ROW_BITS-1:0]    wr_row,
    input  wire [1:0]                        wr_slot,
    input  wire [31:0]                       wdata,
    input  wire [FRAME_BITS+ROW_BITS-1:0]    rd_row,
    output stm_drive_pkg::gain_row_t         rdata
);

    localparam int ROWS = 2 ** (FRAME_BITS + ROW_BITS);

    stm_drive_pkg::gain_row_t mem [ROWS];
    stm_drive_pkg::gain_row_t rd_q;                     // Array output stage

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wr_row][wr_slot] <= wdata;
        end
    end

    // Read port, address to data in two clocks
    always_ff @(posedge CLK) begin
        rd_q  <= mem[rd_row];
        rdata <= rd_q;                                  // Output register
    end

endmodule

`default_nettype wire

// File: verilog/stm_host_decode.sv
// ------------------------------------------------------------
// Host decoder: single-wait Wishbone classic slave for the
// gain memory and the index, mode, cycle and update registers
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_host_decode #(
    parameter int FRAME_BITS = 3,
    parameter int ROW_BITS   = 2
) (
    input  wire                                  CLK,
    input  wire                                  RST,
    input  wire stm_bus_pkg::wb_req_t            wb_req,
    output stm_bus_pkg::wb_rsp_t                 wb_rsp,
    output logic                                 ram_we,
    output logic [FRAME_BITS+ROW_BITS-1:0]       ram_row,
    output logic [1:0]                           ram_slot,
    output logic [31:0]                          ram_wdata,
    output logic [FRAME_BITS-1:0]                frame_index,
    output stm_drive_pkg::gain_fmt_t             fmt,
    output logic [stm_drive_pkg::DRIVE_W-1:0]    cycle,
    input  wire                                  update
);

    logic        access;
    logic        is_reg;
    logic        ack;
    logic [31:0] rdat;
    logic [31:0] rdat_next;
    logic [15:0] update_cnt;

    assign access = wb_req.cyc & wb_req.stb & ~ack;     // Seen with ack low
    assign is_reg = wb_req.adr[7];

    // Memory writes land on the same edge that raises ack
    assign ram_we    = access & wb_req.we & ~is_reg;
    assign ram_row   = wb_req.adr[FRAME_BITS+ROW_BITS+1:2];
    assign ram_slot  = wb_req.adr[1:0];
    assign ram_wdata = wb_req.dat;

    assign wb_rsp = '{ack: ack, dat: rdat};

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    always_comb begin
        case (wb_req.adr)
            stm_bus_pkg::REG_INDEX:   rdat_next = 32'(frame_index);
            stm_bus_pkg::REG_MODE:    rdat_next = {31'd0, fmt};
            stm_bus_pkg::REG_CYCLE:   rdat_next = 32'(cycle);
            stm_bus_pkg::REG_UPDATES: rdat_next = {16'd0, update_cnt};
            default:                  rdat_next = 32'd0;  // Memory is write only
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            ack         <= 1'b0;
            rdat        <= 32'd0;
            frame_index <= '0;
            fmt         <= stm_drive_pkg::FMT_NORMAL;
            cycle       <= '0;
            update_cnt  <= 16'd0;
        end else begin
            ack <= access;                              // One cycle wide
            if (access) begin
                rdat <= rdat_next;
            end
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    stm_bus_pkg::REG_INDEX: frame_index <= wb_req.dat[FRAME_BITS-1:0];
                    stm_bus_pkg::REG_MODE:  fmt <= stm_drive_pkg::gain_fmt_t'(wb_req.dat[0]);
                    stm_bus_pkg::REG_CYCLE: cycle <= wb_req.dat[stm_drive_pkg::DRIVE_W-1:0];
                    default: ;                          // UPDATES is read only
                endcase
            end
            if (update) begin
                update_cnt <= update_cnt + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/stm_top.sv
// ------------------------------------------------------------
// Gain sequence top: host decoder, gain memory, operator
// and drive limiter
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module stm_top #(
    parameter int DEPTH      = 10,
    parameter int FRAME_BITS = 3,
    parameter int ROW_BITS   = 2     // 4 * 2**ROW_BITS must cover DEPTH
) (
    input  wire                                      CLK,
    input  wire                                      RST,
    input  wire stm_bus_pkg::wb_req_t                wb_req,
    output stm_bus_pkg::wb_rsp_t                     wb_rsp,
    output stm_drive_pkg::chan_drive_t [DEPTH-1:0]   DRIVE,
    output logic                                     UPDATE
);

    logic                                     ram_we;
    logic [FRAME_BITS+ROW_BITS-1:0]           ram_row;
    logic [1:0]                               ram_slot;
    logic [31:0]                              ram_wdata;
    logic [FRAME_BITS-1:0]                    frame_index;
    stm_drive_pkg::gain_fmt_t                 fmt;
    logic [stm_drive_pkg::DRIVE_W-1:0]        cycle;
    logic [FRAME_BITS+ROW_BITS-1:0]           rd_row;
    stm_drive_pkg::gain_row_t                 rdata;
    stm_drive_pkg::chan_drive_t [DEPTH-1:0]   drive_buf;
    logic                                     done;

    stm_host_decode #(
        .FRAME_BITS (FRAME_BITS),
        .ROW_BITS   (ROW_BITS)
    ) u_decode (
        .CLK         (CLK),
        .RST         (RST),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .ram_we      (ram_we),
        .ram_row     (ram_row),
        .ram_slot    (ram_slot),
        .ram_wdata   (ram_wdata),
        .frame_index (frame_index),
        .fmt         (fmt),
        .cycle       (cycle),
        .update      (UPDATE)
    );

    stm_gain_ram #(
        .FRAME_BITS (FRAME_BITS),
        .ROW_BITS   (ROW_BITS)
    ) u_ram (
        .CLK     (CLK),
        .we      (ram_we),
        .wr_row  (ram_row),
        .wr_slot (ram_slot),
        .wdata   (ram_wdata),
        .rd_row  (rd_row),
        .rdata   (rdata)
    );

    stm_gain_operator #(
        .DEPTH      (DEPTH),
        .FRAME_BITS (FRAME_BITS),
        .ROW_BITS   (ROW_BITS)
    ) u_operator (
        .CLK         (CLK),
        .RST         (RST),
        .frame_index (frame_index),
        .fmt         (fmt),
        .rd_row      (rd_row),
        .rdata       (rdata),
        .drive_buf   (drive_buf),
        .done        (done)
    );

    stm_drive_limiter #(
        .DEPTH (DEPTH)
    ) u_limiter (
        .CLK       (CLK),
        .RST       (RST),
        .drive_buf (drive_buf),
        .done      (done),
        .cycle     (cycle),
        .drive     (DRIVE),
        .update    (UPDATE)
    );

endmodule

`default_nettype wire
